//--- zxuno_pkg.sv
`default_nettype none

package zxuno_pkg;

   // ------------------------------
   // I/O ports seen by the Z80
   // ------------------------------

   // Register number select, read back gives the current number
   localparam logic [15:0] PORT_REGADDR = 16'hFC3B;
   // Data port for the selected register
   localparam logic [15:0] PORT_REGDATA = 16'hFD3B;

   // Value on the data bus when nobody answers
   localparam logic [7:0] BUS_IDLE_DATA = 8'hFF;

   // ------------------------------
   // Register numbers
   // ------------------------------

   typedef enum logic [7:0] {
      REG_SCANDBLCTRL = 8'h0B,
      REG_RASTERLINE  = 8'h0C,
      REG_RASTERCTRL  = 8'h0D,
      REG_DEVOPTIONS  = 8'h0E,
      REG_COREID      = 8'hFF
   } zxuno_reg_e;

   // ------------------------------
   // Core identification string
   // ------------------------------

   localparam int COREID_LEN = 4;
   localparam int COREID_PTR_W = $clog2(COREID_LEN);

   // "T42" and a zero terminator, element 0 is read first
   localparam logic [0:COREID_LEN-1][7:0] COREID_BYTES = {
      8'h54,
      8'h34,
      8'h32,
      8'h00
   };

   // ------------------------------
   // Field widths
   // ------------------------------

   localparam int RASTER_LINE_W = 9;
   localparam int FREQ_OPTION_W = 3;
   localparam int TURBO_W = 2;

endpackage

`default_nettype wire

//--- zxuno_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Register bank bus between the address register and the register modules
interface zxuno_reg_if import zxuno_pkg::*; ();

   zxuno_reg_e  reg_addr;
   logic        reg_rd;           // level, whole FD3B read cycle
   logic        reg_wr;           // first clock of an FD3B write
   logic        reg_rd_done;      // clock after an FD3B read ends
   logic        regaddr_changed;  // FC3B was just written
   logic [7:0]  wdata;

   modport source (
      output reg_addr,
      output reg_rd,
      output reg_wr,
      output reg_rd_done,
      output regaddr_changed,
      output wdata
   );

   modport sink (
      input reg_addr,
      input reg_rd,
      input reg_wr,
      input reg_rd_done,
      input regaddr_changed,
      input wdata
   );

endinterface

`default_nettype wire

//--- zxuno_regaddr.sv
`timescale 1ns/1ps
`default_nettype none

module zxuno_regaddr import zxuno_pkg::*; (
   input  logic        sysclk,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   output logic [7:0]  dout,
   output logic        oe_n,
   zxuno_reg_if.source bus
);

   logic        io_rd;
   logic        io_wr;
   logic        addr_rd;
   logic        addr_wr;
   logic        data_rd;
   logic        data_wr;
   logic        addr_wr_q;
   logic        data_wr_q;
   logic        data_rd_q;
   logic        rd_done_q;
   logic        changed_q;
   zxuno_reg_e  reg_addr_q;

   // ------------------------------
   // Port decode
   // ------------------------------

   assign io_rd = ~iorq_n & ~rd_n;
   assign io_wr = ~iorq_n & ~wr_n;

   assign addr_rd = io_rd & (a == PORT_REGADDR);
   assign addr_wr = io_wr & (a == PORT_REGADDR);
   assign data_rd = io_rd & (a == PORT_REGDATA);
   assign data_wr = io_wr & (a == PORT_REGDATA);

   // Strobe history for the edge detectors
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         addr_wr_q <= 1'b0;
         data_wr_q <= 1'b0;
         data_rd_q <= 1'b0;
      end else begin
         addr_wr_q <= addr_wr;
         data_wr_q <= data_wr;
         data_rd_q <= data_rd;
      end
   end

   // ------------------------------
   // Register number
   // ------------------------------

   // Loaded once per FC3B write, on its first clock
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         reg_addr_q <= zxuno_reg_e'(8'h00);
         changed_q  <= 1'b0;
      end else begin
         changed_q <= addr_wr & ~addr_wr_q;
         if (addr_wr && !addr_wr_q) begin
            reg_addr_q <= zxuno_reg_e'(din);
         end
      end
   end

   // Falling edge of the FD3B read, one clock late
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         rd_done_q <= 1'b0;
      end else begin
         rd_done_q <= data_rd_q & ~data_rd;
      end
   end

   assign bus.reg_addr        = reg_addr_q;
   assign bus.reg_rd          = data_rd;
   assign bus.reg_wr          = data_wr & ~data_wr_q;
   assign bus.reg_rd_done     = rd_done_q;
   assign bus.regaddr_changed = changed_q;
   // Z80 keeps the byte stable for the whole write cycle
   assign bus.wdata           = din;

   // Read back of the selected number
   assign dout = reg_addr_q;
   assign oe_n = ~addr_rd;

endmodule

`default_nettype wire

//--- coreid_rom.sv
`timescale 1ns/1ps
`default_nettype none

module coreid_rom import zxuno_pkg::*; (
   input  logic       sysclk,
   input  logic       rst_n,
   zxuno_reg_if.sink  bus,
   output logic [7:0] dout,
   output logic       oe_n
);

   logic [COREID_PTR_W-1:0] ptr;
   logic                    sel;

   assign sel = (bus.reg_addr == REG_COREID);

   // ------------------------------
   // String pointer
   // ------------------------------

   // Selecting any register restarts the string
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (bus.regaddr_changed) begin
         ptr <= '0;
      end else if (bus.reg_rd_done && sel) begin
         if (ptr == COREID_PTR_W'(COREID_LEN - 1)) begin
            // Back to the first byte after the terminator
            ptr <= '0;
         end else begin
            ptr <= ptr + COREID_PTR_W'(1);
         end
      end
   end

   assign dout = COREID_BYTES[ptr];
   assign oe_n = ~(bus.reg_rd & sel);

endmodule

`default_nettype wire

//--- device_options.sv
`timescale 1ns/1ps
`default_nettype none

module device_options import zxuno_pkg::*; (
   input  logic       sysclk,
   input  logic       rst_n,
   zxuno_reg_if.sink  bus,
   output logic [7:0] dout,
   output logic       oe_n,
   output logic [7:0] device_options_q
);

   logic       sel;
   logic [7:0] options_q;

   assign sel = (bus.reg_addr == REG_DEVOPTIONS);

   // One disable bit per device, all devices on after reset
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         options_q <= 8'h00;
      end else if (bus.reg_wr && sel) begin
         options_q <= bus.wdata;
      end
   end

   assign device_options_q = options_q;

   assign dout = options_q;
   assign oe_n = ~(bus.reg_rd & sel);

endmodule

`default_nettype wire

//--- scandoubler_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module scandoubler_ctrl import zxuno_pkg::*; (
   input  logic                     sysclk,
   input  logic                     rst_n,
   zxuno_reg_if.sink                bus,
   output logic [7:0]               dout,
   output logic                     oe_n,
   output logic                     vga_enable,
   output logic                     scanlines_enable,
   output logic                     csync_option,
   output logic [FREQ_OPTION_W-1:0] freq_option,
   output logic [TURBO_W-1:0]       turbo_option
);

   logic       sel;
   logic [7:0] ctrl_q;

   assign sel = (bus.reg_addr == REG_SCANDBLCTRL);

   // ------------------------------
   // Control byte
   // ------------------------------

   // Composite video, normal speed after reset
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_q <= 8'h00;
      end else if (bus.reg_wr && sel) begin
         ctrl_q <= bus.wdata;
      end
   end

   // Field split
   assign vga_enable       = ctrl_q[0];
   assign scanlines_enable = ctrl_q[1];
   assign freq_option      = ctrl_q[4:2];
   assign csync_option     = ctrl_q[5];
   assign turbo_option     = ctrl_q[7:6];

   // Whole byte read back
   assign dout = ctrl_q;
   assign oe_n = ~(bus.reg_rd & sel);

endmodule

`default_nettype wire

//--- rasterint_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rasterint_ctrl import zxuno_pkg::*; (
   input  logic                     sysclk,
   input  logic                     rst_n,
   zxuno_reg_if.sink                bus,
   output logic [7:0]               dout,
   output logic                     oe_n,
   output logic [RASTER_LINE_W-1:0] raster_line,
   output logic                     rasterint_enable,
   output logic                     vretraceint_disable
);

   logic       sel_line;
   logic       sel_ctrl;
   logic [7:0] line_q;
   logic [2:0] ctrl_q;

   assign sel_line = (bus.reg_addr == REG_RASTERLINE);
   assign sel_ctrl = (bus.reg_addr == REG_RASTERCTRL);

   // ------------------------------
   // Line and control registers
   // ------------------------------

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         line_q <= 8'h00;
         ctrl_q <= 3'b000;
      end else if (bus.reg_wr) begin
         if (sel_line) begin
            line_q <= bus.wdata;
         end
         if (sel_ctrl) begin
            ctrl_q <= bus.wdata[2:0];
         end
      end
   end

   // Bit 8 of the line lives in the control register
   assign raster_line         = {ctrl_q[0], line_q};
   assign rasterint_enable    = ctrl_q[1];
   assign vretraceint_disable = ctrl_q[2];

   // Upper control bits read as zero
   assign dout = sel_ctrl ? {5'b00000, ctrl_q} : line_q;
   assign oe_n = ~(bus.reg_rd & (sel_line | sel_ctrl));

endmodule

`default_nettype wire

//--- zxuno_core.sv
`timescale 1ns/1ps
`default_nettype none

module zxuno_core import zxuno_pkg::*; (
   input  logic                     sysclk,
   input  logic                     rst_n,

   // Z80 I/O bus
   input  logic [15:0]              a,
   input  logic [7:0]               din,
   output logic [7:0]               dout,
   input  logic                     iorq_n,
   input  logic                     rd_n,
   input  logic                     wr_n,

   // Configuration outputs
   output logic [7:0]               device_options_q,
   output logic                     vga_enable,
   output logic                     scanlines_enable,
   output logic                     csync_option,
   output logic [FREQ_OPTION_W-1:0] freq_option,
   output logic [TURBO_W-1:0]       turbo_option,
   output logic [RASTER_LINE_W-1:0] raster_line,
   output logic                     rasterint_enable,
   output logic                     vretraceint_disable
);

   // Read bytes and enables of each device
   logic [7:0] regaddr_dout;
   logic [7:0] coreid_dout;
   logic [7:0] devoptions_dout;
   logic [7:0] scndblctrl_dout;
   logic [7:0] rasterint_dout;
   logic       oe_n_regaddr;
   logic       oe_n_coreid;
   logic       oe_n_devoptions;
   logic       oe_n_scndblctrl;
   logic       oe_n_rasterint;

   zxuno_reg_if reg_bus ();

   // ------------------------------
   // Register bank
   // ------------------------------

   zxuno_regaddr u_regaddr (
      .sysclk (sysclk),
      .rst_n  (rst_n),
      .a      (a),
      .din    (din),
      .iorq_n (iorq_n),
      .rd_n   (rd_n),
      .wr_n   (wr_n),
      .dout   (regaddr_dout),
      .oe_n   (oe_n_regaddr),
      .bus    (reg_bus)
   );

   coreid_rom u_coreid (
      .sysclk (sysclk),
      .rst_n  (rst_n),
      .bus    (reg_bus),
      .dout   (coreid_dout),
      .oe_n   (oe_n_coreid)
   );

   device_options u_devoptions (
      .sysclk           (sysclk),
      .rst_n            (rst_n),
      .bus              (reg_bus),
      .dout             (devoptions_dout),
      .oe_n             (oe_n_devoptions),
      .device_options_q (device_options_q)
   );

   scandoubler_ctrl u_scndblctrl (
      .sysclk           (sysclk),
      .rst_n            (rst_n),
      .bus              (reg_bus),
      .dout             (scndblctrl_dout),
      .oe_n             (oe_n_scndblctrl),
      .vga_enable       (vga_enable),
      .scanlines_enable (scanlines_enable),
      .csync_option     (csync_option),
      .freq_option      (freq_option),
      .turbo_option     (turbo_option)
   );

   rasterint_ctrl u_rasterint (
      .sysclk              (sysclk),
      .rst_n               (rst_n),
      .bus                 (reg_bus),
      .dout                (rasterint_dout),
      .oe_n                (oe_n_rasterint),
      .raster_line         (raster_line),
      .rasterint_enable    (rasterint_enable),
      .vretraceint_disable (vretraceint_disable)
   );

   // ------------------------------
   // Read data multiplexer
   // ------------------------------

   // First active enable wins, idle bus otherwise
   always_comb begin
      case (1'b0)
         oe_n_regaddr    : dout = regaddr_dout;
         oe_n_coreid     : dout = coreid_dout;
         oe_n_devoptions : dout = devoptions_dout;
         oe_n_scndblctrl : dout = scndblctrl_dout;
         oe_n_rasterint  : dout = rasterint_dout;
         default         : dout = BUS_IDLE_DATA;
      endcase
   end

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// Free running clock, 100 ns period
module tb_clock (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

endmodule

`default_nettype wire

//--- zxuno_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module zxuno_core_tb;

   localparam logic [15:0] ADDR_PORT  = 16'hFC3B;
   localparam logic [15:0] DATA_PORT  = 16'hFD3B;
   localparam logic [15:0] OTHER_PORT = 16'h7FFD;
   localparam logic [7:0]  SCANDBL    = 8'h0B;
   localparam logic [7:0]  RLINE      = 8'h0C;
   localparam logic [7:0]  RCTRL      = 8'h0D;
   localparam logic [7:0]  DEVOPT     = 8'h0E;
   localparam logic [7:0]  COREID     = 8'hFF;

   localparam int N_SELECT = 8;
   localparam int N_ROUNDS = 4;
   // Bus cycles over all tests, each one 3 clocks held plus 1 idle
   localparam int BUS_CYCLES  = 3 + 2 * N_SELECT + 12 * N_ROUNDS + 9;
   localparam int TEST_CYCLES = 5 + 4 * BUS_CYCLES;
   localparam int WATCHDOG_NS = 20 * TEST_CYCLES * 100;

   logic        sysclk;
   logic        rst_n;
   logic [15:0] a;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  device_options_q;
   logic        vga_enable;
   logic        scanlines_enable;
   logic        csync_option;
   logic [2:0]  freq_option;
   logic [1:0]  turbo_option;
   logic [8:0]  raster_line;
   logic        rasterint_enable;
   logic        vretraceint_disable;

   int test_errors = 0;
   int pass_count = 0;
   int fail_count = 0;

   // "T42" and its terminator
   logic [7:0] coreid_exp [4] = '{8'h54, 8'h34, 8'h32, 8'h00};

   tb_clock u_clock (.clk(sysclk));

   zxuno_core dut (
      .sysclk              (sysclk),
      .rst_n               (rst_n),
      .a                   (a),
      .din                 (din),
      .dout                (dout),
      .iorq_n              (iorq_n),
      .rd_n                (rd_n),
      .wr_n                (wr_n),
      .device_options_q    (device_options_q),
      .vga_enable          (vga_enable),
      .scanlines_enable    (scanlines_enable),
      .csync_option        (csync_option),
      .freq_option         (freq_option),
      .turbo_option        (turbo_option),
      .raster_line         (raster_line),
      .rasterint_enable    (rasterint_enable),
      .vretraceint_disable (vretraceint_disable)
   );

   // ------------------------------
   // Bus cycles and reporting
   // ------------------------------

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("ERROR %s: got %0h, expected %0h", name, got, exp);
      test_errors++;
   endtask

   task automatic close_test(input string name);
      if (test_errors == 0) begin
         $display("%s: ok", name);
         pass_count++;
      end else begin
         $display("%s: %0d mismatches", name, test_errors);
         fail_count++;
      end
      test_errors = 0;
   endtask

   // Called 10 ns after a rising edge, returns at the same phase
   task automatic io_write(input logic [15:0] port, input logic [7:0] data);
      a = port;
      din = data;
      iorq_n = 1'b0;
      wr_n = 1'b0;
      repeat (3) @(posedge sysclk);
      #10;
      iorq_n = 1'b1;
      wr_n = 1'b1;
      @(posedge sysclk);
      #10;
   endtask

   task automatic io_read(input logic [15:0] port, output logic [7:0] data);
      a = port;
      iorq_n = 1'b0;
      rd_n = 1'b0;
      repeat (2) @(posedge sysclk);
      // Middle of the last clock of the cycle
      #50;
      data = dout;
      @(posedge sysclk);
      #10;
      iorq_n = 1'b1;
      rd_n = 1'b1;
      @(posedge sysclk);
      #10;
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------

   task automatic check_after_reset();
      logic [7:0] rd;
      if (device_options_q !== 8'h00) report_mismatch("device_options_q", 32'(device_options_q), 0);
      if (vga_enable !== 1'b0) report_mismatch("vga_enable", 32'(vga_enable), 0);
      if (scanlines_enable !== 1'b0) report_mismatch("scanlines_enable", 32'(scanlines_enable), 0);
      if (csync_option !== 1'b0) report_mismatch("csync_option", 32'(csync_option), 0);
      if (freq_option !== 3'd0) report_mismatch("freq_option", 32'(freq_option), 0);
      if (turbo_option !== 2'd0) report_mismatch("turbo_option", 32'(turbo_option), 0);
      if (raster_line !== 9'd0) report_mismatch("raster_line", 32'(raster_line), 0);
      if (rasterint_enable !== 1'b0) report_mismatch("rasterint_enable", 32'(rasterint_enable), 0);
      if (vretraceint_disable !== 1'b0)
         report_mismatch("vretraceint_disable", 32'(vretraceint_disable), 0);
      io_read(ADDR_PORT, rd);
      if (rd !== 8'h00) report_mismatch("dout", 32'(rd), 32'h00);
      // Register 00 is not kept, so the bus stays idle
      io_read(DATA_PORT, rd);
      if (rd !== 8'hFF) report_mismatch("dout", 32'(rd), 32'hFF);
      io_read(OTHER_PORT, rd);
      if (rd !== 8'hFF) report_mismatch("dout", 32'(rd), 32'hFF);
      close_test("after_reset");
   endtask

   task automatic select_readback();
      logic [7:0] num;
      logic [7:0] rd;
      for (int i = 0; i < N_SELECT; i++) begin
         num = 8'($urandom);
         io_write(ADDR_PORT, num);
         io_read(ADDR_PORT, rd);
         if (rd !== num) report_mismatch("dout", 32'(rd), 32'(num));
      end
      close_test("register_select");
   endtask

   task automatic options_and_scandoubler();
      logic [7:0] dv;
      logic [7:0] sc;
      logic [7:0] rd;
      for (int i = 0; i < N_ROUNDS; i++) begin
         dv = 8'($urandom);
         sc = 8'($urandom);
         io_write(ADDR_PORT, DEVOPT);
         io_write(DATA_PORT, dv);
         io_read(DATA_PORT, rd);
         if (rd !== dv) report_mismatch("dout", 32'(rd), 32'(dv));
         if (device_options_q !== dv)
            report_mismatch("device_options_q", 32'(device_options_q), 32'(dv));
         io_write(ADDR_PORT, SCANDBL);
         io_write(DATA_PORT, sc);
         io_read(DATA_PORT, rd);
         if (rd !== sc) report_mismatch("dout", 32'(rd), 32'(sc));
         if (vga_enable !== sc[0]) report_mismatch("vga_enable", 32'(vga_enable), 32'(sc[0]));
         if (scanlines_enable !== sc[1])
            report_mismatch("scanlines_enable", 32'(scanlines_enable), 32'(sc[1]));
         if (freq_option !== sc[4:2])
            report_mismatch("freq_option", 32'(freq_option), 32'(sc[4:2]));
         if (csync_option !== sc[5])
            report_mismatch("csync_option", 32'(csync_option), 32'(sc[5]));
         if (turbo_option !== sc[7:6])
            report_mismatch("turbo_option", 32'(turbo_option), 32'(sc[7:6]));
      end
      close_test("options_scandoubler");
   endtask

   task automatic raster_registers();
      logic [8:0] line;
      logic [7:0] ctrl;
      logic [7:0] rd;
      for (int i = 0; i < N_ROUNDS; i++) begin
         line = 9'($urandom);
         // Random upper bits must not show up on read back
         ctrl = {5'($urandom), 2'($urandom), line[8]};
         io_write(ADDR_PORT, RLINE);
         io_write(DATA_PORT, line[7:0]);
         io_read(DATA_PORT, rd);
         if (rd !== line[7:0]) report_mismatch("dout", 32'(rd), 32'(line[7:0]));
         io_write(ADDR_PORT, RCTRL);
         io_write(DATA_PORT, ctrl);
         io_read(DATA_PORT, rd);
         if (rd !== {5'b00000, ctrl[2:0]})
            report_mismatch("dout", 32'(rd), 32'({5'b00000, ctrl[2:0]}));
         if (raster_line !== line) report_mismatch("raster_line", 32'(raster_line), 32'(line));
         if (rasterint_enable !== ctrl[1])
            report_mismatch("rasterint_enable", 32'(rasterint_enable), 32'(ctrl[1]));
         if (vretraceint_disable !== ctrl[2])
            report_mismatch("vretraceint_disable", 32'(vretraceint_disable), 32'(ctrl[2]));
      end
      close_test("raster");
   endtask

   task automatic coreid_sequence();
      logic [1:0] idx;
      logic [7:0] rd;
      idx = 2'd0;
      io_write(ADDR_PORT, COREID);
      for (int i = 0; i < 6; i++) begin
         io_read(DATA_PORT, rd);
         if (rd !== coreid_exp[idx]) report_mismatch("dout", 32'(rd), 32'(coreid_exp[idx]));
         idx = idx + 2'd1;
      end
      // Selecting again restarts the string
      io_write(ADDR_PORT, COREID);
      io_read(DATA_PORT, rd);
      if (rd !== coreid_exp[0]) report_mismatch("dout", 32'(rd), 32'(coreid_exp[0]));
      close_test("coreid");
   endtask

   // ------------------------------
   // Run control
   // ------------------------------

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

   initial begin
      a = 16'h0000;
      din = 8'h00;
      iorq_n = 1'b1;
      rd_n = 1'b1;
      wr_n = 1'b1;
      rst_n = 1'b0;
      void'($urandom(32'ha6b8));
      repeat (5) @(posedge sysclk);
      #10;
      rst_n = 1'b1;
      check_after_reset();
      select_readback();
      options_and_scandoubler();
      raster_registers();
      coreid_sequence();
      $display("summary: %0d tests ok, %0d tests failing", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- zxuno_core.f
zxuno_pkg.sv
zxuno_reg_if.sv
zxuno_regaddr.sv
coreid_rom.sv
device_options.sv
scandoubler_ctrl.sv
rasterint_ctrl.sv
zxuno_core.sv
tb_clock.sv
zxuno_core_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = zxuno_core_tb
FILELIST  = zxuno_core.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
